/* src.f */
source/acq_pkg.sv
source/sample_buffer.sv
source/acq_control.sv
source/wb_command_port.sv
source/sample_store.sv
source/acq_top.sv
dv/acq_clock_gen.sv
dv/acq_tb.sv

/* dv/acq_tb.sv */
`timescale 1ns/10ps

module acq_tb;
   import acq_pkg::*;

   localparam int SAMPLE_GAP     = 6;                          // Cycles per forwarded sample.
   localparam int WAIT_LIMIT     = 20;                         // Longest wait for a flag.
   localparam int TIMEOUT_CYCLES = STORE_DEPTH * 6 + 600 + 200;

   logic    clock;
   logic    reset;
   logic    enable_i;
   logic    strobe_i;
   sample_t sample_i;
   logic    rd_req_i;
   logic    rd_valid_o;
   sample_t rd_data_o;
   logic    overflow_o;
   logic    readback_o;
   logic    finished_o;

   logic [15:0] lfsr_q = 16'd22;   // Seed.
   sample_t     accepted_q[$];      // Samples taken in by the buffer, in order.
   int          read_count = 0;
   int          checks = 0;
   int          errors = 0;
   int          cycle_count = 0;

   acq_clock_gen acq_clock_gen_i (
      .clock_o (clock),
      .reset_o (reset)
   );

   acq_top acq_top_i (
      .clock_i    (clock),
      .reset_i    (reset),
      .enable_i   (enable_i),
      .strobe_i   (strobe_i),
      .sample_i   (sample_i),
      .rd_req_i   (rd_req_i),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o),
      .overflow_o (overflow_o),
      .readback_o (readback_o),
      .finished_o (finished_o)
   );

   // --------------------
   // Helpers.
   // --------------------
   // x^16 + x^14 + x^13 + x^11, Fibonacci form.
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
   endfunction

   // One LFSR step per sample bit.
   task automatic next_sample(output sample_t value);
      value = '0;
      for (int b = 0; b < SAMPLE_W; b++) begin
         lfsr_q = lfsr_step(lfsr_q);
         value  = {value[SAMPLE_W-2:0], lfsr_q[0]};
      end
   endtask

   // Store read-back returns samples in acceptance order.
   function automatic sample_t expected_word(input int index);
      return accepted_q[index];
   endfunction

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else begin
         errors++;
         $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1)
      else begin
         errors++;
         $display("%s", what);
      end
   endtask

   // Inputs change 5 ns after the edge.
   task automatic next_cycle();
      @(posedge clock);
      #5;
   endtask

   task automatic wait_rd_valid(output logic seen);
      seen = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
         next_cycle();
         seen = rd_valid_o;
      end
   endtask

   task automatic pulse_rd_req();
      rd_req_i = 1'b1;
      next_cycle();
      rd_req_i = 1'b0;
   endtask

   // --------------------
   // Comparison process.
   // --------------------
   // Outputs are settled at the falling edge.
   always @(negedge clock) begin
      if (!reset && rd_valid_o) begin
         if (read_count < STORE_DEPTH) begin
            check_value($sformatf("readback word %0d", read_count),
                        expected_word(read_count), rd_data_o);
         end else begin
            check_true(1'b0, "rd_valid_o pulsed after every word was read back");
         end
         read_count++;
      end
   end

   // --------------------
   // Timeout.
   // --------------------
   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks: %0d, errors: %0d", checks, errors + 1);
         $display(">>> FAIL");
         $finish;
      end
   end

   // --------------------
   // Stimulus.
   // --------------------
   initial begin
      sample_t s;
      logic    seen;
      enable_i = 1'b1;
      strobe_i = 1'b0;
      sample_i = '0;
      rd_req_i = 1'b0;

      // Reset state, during and after reset.
      next_cycle();
      check_value("reset rd_valid", 0, rd_valid_o);
      check_value("reset overflow", 0, overflow_o);
      check_value("reset readback", 0, readback_o);
      check_value("reset finished", 0, finished_o);
      @(negedge reset);
      next_cycle();
      check_value("post reset rd_valid", 0, rd_valid_o);
      check_value("post reset overflow", 0, overflow_o);
      check_value("post reset readback", 0, readback_o);
      check_value("post reset finished", 0, finished_o);

      // Fill the store, one sample per gap.
      for (int i = 0; i < STORE_DEPTH; i++) begin
         next_sample(s);
         sample_i = s;
         strobe_i = 1'b1;
         accepted_q.push_back(s);
         next_cycle();
         strobe_i = 1'b0;
         repeat (SAMPLE_GAP - 1) next_cycle();
         check_value("no overflow while forwarding", 0, overflow_o);
      end

      // First word comes back unasked.
      seen = readback_o;
      for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
         next_cycle();
         seen = readback_o;
      end
      check_true(seen, "readback_o did not rise after the store filled");
      wait_rd_valid(seen);
      check_true(seen, "first read-back word did not arrive without a request");

      // Remaining words, one request each.
      for (int i = 1; i < STORE_DEPTH; i++) begin
         pulse_rd_req();
         wait_rd_valid(seen);
         check_true(seen, $sformatf("no rd_valid_o for read request %0d", i));
      end

      // Finished flag, later requests ignored.
      seen = finished_o;
      for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
         next_cycle();
         seen = finished_o;
      end
      check_true(seen, "finished_o did not rise after the last word");
      repeat (3) begin
         pulse_rd_req();
         repeat (8) next_cycle();
      end
      check_value("read-back word count", STORE_DEPTH, read_count);
      check_value("finished stays high", 1, finished_o);

      // Burst into the buffer, 17th strobe overflows.
      check_value("overflow before burst", 0, overflow_o);
      for (int i = 1; i <= BUF_DEPTH + 1; i++) begin
         next_sample(s);
         sample_i = s;
         strobe_i = 1'b1;
         if (i <= BUF_DEPTH) accepted_q.push_back(s);   // 17th is dropped.
         next_cycle();
         check_value($sformatf("burst overflow after strobe %0d", i),
                     (i > BUF_DEPTH), overflow_o);
      end
      strobe_i = 1'b0;

      // Enable low for one cycle clears overflow.
      enable_i = 1'b0;
      strobe_i = 1'b1;
      next_cycle();
      check_value("overflow cleared with enable low", 0, overflow_o);
      enable_i = 1'b1;
      strobe_i = 1'b0;
      next_cycle();
      check_value("overflow stays clear", 0, overflow_o);
      strobe_i = 1'b1;
      next_cycle();
      strobe_i = 1'b0;
      check_value("overflow again on full buffer", 1, overflow_o);

      repeat (4) next_cycle();
      check_value("final read-back word count", STORE_DEPTH, read_count);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* dv/acq_clock_gen.sv */
`timescale 1ns/10ps

module acq_clock_gen (
   output logic clock_o,
   output logic reset_o
);

   // 100 ns period.
   initial begin
      clock_o = 1'b0;
      forever #50 clock_o = ~clock_o;
   end

   // Reset held over the first two rising edges.
   initial begin
      reset_o = 1'b1;
      repeat (2) @(posedge clock_o);
      #5 reset_o = 1'b0;   // Same skew as the stimulus.
   end

endmodule

/* source/acq_top.sv */
`timescale 1ns/10ps

module acq_top (
   input  logic             clock_i,
   input  logic             reset_i,
   input  logic             enable_i,
   input  logic             strobe_i,
   input  acq_pkg::sample_t sample_i,
   input  logic             rd_req_i,
   output logic             rd_valid_o,
   output acq_pkg::sample_t rd_data_o,
   output logic             overflow_o,
   output logic             readback_o,
   output logic             finished_o
);
   import acq_pkg::*;

   // --------------------
   // Internal wiring.
   // --------------------
   logic     empty_n;   // Buffer holds data.
   sample_t  head;      // Oldest buffered sample.
   logic     pop;
   mem_cmd_t cmd;
   mem_rsp_t rsp;
   wb_m2s_t  wb_m2s;
   wb_s2m_t  wb_s2m;

   sample_buffer sample_buffer_i (
      .clock_i    (clock_i),
      .reset_i    (reset_i),
      .enable_i   (enable_i),
      .strobe_i   (strobe_i),
      .sample_i   (sample_i),
      .pop_i      (pop),
      .empty_n_o  (empty_n),
      .head_o     (head),
      .overflow_o (overflow_o)
   );

   acq_control acq_control_i (
      .clock_i    (clock_i),
      .reset_i    (reset_i),
      .enable_i   (enable_i),
      .empty_n_i  (empty_n),
      .head_i     (head),
      .rd_req_i   (rd_req_i),
      .rsp_i      (rsp),
      .pop_o      (pop),
      .cmd_o      (cmd),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o),
      .readback_o (readback_o),
      .finished_o (finished_o)
   );

   // Command to Wishbone bridge.
   wb_command_port wb_command_port_i (
      .clock_i (clock_i),
      .reset_i (reset_i),
      .cmd_i   (cmd),
      .wb_i    (wb_s2m),
      .rsp_o   (rsp),
      .wb_o    (wb_m2s)
   );

   sample_store sample_store_i (
      .clock_i (clock_i),
      .reset_i (reset_i),
      .wb_i    (wb_m2s),
      .wb_o    (wb_s2m)
   );

endmodule

/* source/sample_store.sv */
`timescale 1ns/10ps

module sample_store (
   input  logic             clock_i,
   input  logic             reset_i,
   input  acq_pkg::wb_m2s_t wb_i,
   output acq_pkg::wb_s2m_t wb_o
);
   import acq_pkg::*;

   bus_data_t mem [STORE_DEPTH];   // On-chip stand-in for external RAM.
   logic      ack_q;
   bus_data_t rdat_q;
   logic      access;

   assign access = wb_i.cyc && wb_i.stb;

   // --------------------
   // Acknowledge.
   // --------------------
   // One cycle after the strobe, never two in a row.
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access && !ack_q;
      end
   end

   // --------------------
   // Memory.
   // --------------------
   // Write lands at the end of the ack cycle.
   always_ff @(posedge clock_i) begin
      if (access && wb_i.we && ack_q) begin
         mem[wb_i.adr] <= wb_i.dat;
      end
   end

   // Read data registered together with ack.
   always_ff @(posedge clock_i) begin
      if (access && !ack_q) begin
         rdat_q <= mem[wb_i.adr];
      end
   end

   assign wb_o = '{ack: ack_q, dat: rdat_q};

endmodule

/* source/wb_command_port.sv */
`timescale 1ns/10ps

module wb_command_port (
   input  logic              clock_i,
   input  logic              reset_i,
   input  acq_pkg::mem_cmd_t cmd_i,
   input  acq_pkg::wb_s2m_t  wb_i,
   output acq_pkg::mem_rsp_t rsp_o,
   output acq_pkg::wb_m2s_t  wb_o
);
   import acq_pkg::*;

   logic       cyc_q;
   logic       stb_q;
   logic       acked_q;     // Command served, waiting for request to fall.
   logic       we_q;
   store_adr_t adr_q;
   bus_data_t  dat_q;
   logic       done_q;
   sample_t    rdat_q;
   logic       start;
   logic       ack_seen;

   assign start    = cmd_i.request && !acked_q && !cyc_q;
   assign ack_seen = cyc_q && wb_i.ack;

   // --------------------
   // Bus cycle control.
   // --------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         acked_q <= 1'b0;
      end else if (ack_seen) begin
         cyc_q   <= 1'b0;   // Drop in the cycle after ack.
         stb_q   <= 1'b0;
         acked_q <= 1'b1;
      end else begin
         if (start) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
         end
         if (!cmd_i.request) acked_q <= 1'b0;   // Ready for the next one.
      end
   end

   // Address, direction and write data captured at start.
   always_ff @(posedge clock_i) begin
      if (start) begin
         we_q  <= cmd_i.write;
         adr_q <= cmd_i.address;
         dat_q <= bus_data_t'(cmd_i.data);   // Zero-extended.
      end
   end

   // --------------------
   // Response.
   // --------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) done_q <= 1'b0;
      else         done_q <= ack_seen;
   end

   always_ff @(posedge clock_i) begin
      if (ack_seen) rdat_q <= wb_i.dat[SAMPLE_W-1:0];   // Upper bits unused.
   end

   assign rsp_o = '{done: done_q, data: rdat_q};
   assign wb_o  = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};

   // Slave acknowledges only an open strobe.
   a_ack_in_cyc : assert property (@(posedge clock_i) disable iff (reset_i)
      wb_i.ack |-> (cyc_q && stb_q))
      else $error("wb_command_port: ack outside a bus cycle");

endmodule

/* source/acq_control.sv */
`timescale 1ns/10ps

module acq_control (
   input  logic              clock_i,
   input  logic              reset_i,
   input  logic              enable_i,
   input  logic              empty_n_i,
   input  acq_pkg::sample_t  head_i,
   input  logic              rd_req_i,
   input  acq_pkg::mem_rsp_t rsp_i,
   output logic              pop_o,
   output acq_pkg::mem_cmd_t cmd_o,
   output logic              rd_valid_o,
   output acq_pkg::sample_t  rd_data_o,
   output logic              readback_o,
   output logic              finished_o
);
   import acq_pkg::*;

   aq_state_t  state_q;
   store_ptr_t wr_ptr_q;     // Next store word to fill.
   store_ptr_t rd_ptr_q;     // Next store word to read back.
   logic       req_q;
   logic       write_q;
   store_adr_t adr_q;
   sample_t    data_q;
   logic       store_full;
   logic       reads_done;
   logic       issue_wr;
   logic       issue_rd;

   // --------------------
   // Decode.
   // --------------------
   assign store_full = wr_ptr_q[STORE_AW];   // One full pass written.
   assign reads_done = rd_ptr_q[STORE_AW];   // One full pass read.

   // Forward a buffered sample while the store still has room.
   assign issue_wr = (state_q == AQ_WAITING) && enable_i &&
                     !store_full && empty_n_i;

   // First read starts unasked; the rest wait for a request.
   assign issue_rd = ((state_q == AQ_WAITING) && enable_i && store_full) ||
                     ((state_q == AQ_IDLE) && !reads_done && rd_req_i);

   // Pop in the done cycle so the next head is ready in AQ_WAITING.
   assign pop_o = (state_q == AQ_BUFFERING) && rsp_i.done;

   assign cmd_o = '{request: req_q,
                    write:   write_q,
                    address: adr_q,
                    data:    data_q};

   // --------------------
   // Command payload.
   // --------------------
   // Held stable while request is high.
   always_ff @(posedge clock_i) begin
      if (issue_wr) begin
         adr_q  <= wr_ptr_q[STORE_AW-1:0];
         data_q <= head_i;
      end else if (issue_rd) begin
         adr_q  <= rd_ptr_q[STORE_AW-1:0];
      end
   end

   // Read-back data follows the response.
   always_ff @(posedge clock_i) begin
      if ((state_q == AQ_READBACK) && rsp_i.done) begin
         rd_data_o <= rsp_i.data;
      end
   end

   // --------------------
   // State machine.
   // --------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         state_q    <= AQ_WAITING;
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         req_q      <= 1'b0;
         write_q    <= 1'b0;
         rd_valid_o <= 1'b0;
         readback_o <= 1'b0;
         finished_o <= 1'b0;
      end else begin
         rd_valid_o <= 1'b0;   // Single-cycle pulse.

         case (state_q)
            AQ_WAITING: begin
               if (issue_rd) begin
                  req_q      <= 1'b1;
                  write_q    <= 1'b0;
                  readback_o <= 1'b1;   // Sticky from here on.
                  state_q    <= AQ_READBACK;
               end else if (issue_wr) begin
                  req_q   <= 1'b1;
                  write_q <= 1'b1;
                  state_q <= AQ_BUFFERING;
               end
            end

            AQ_BUFFERING: begin
               if (rsp_i.done) begin
                  req_q    <= 1'b0;
                  wr_ptr_q <= wr_ptr_q + 1'b1;
                  state_q  <= AQ_WAITING;
               end
            end

            AQ_READBACK: begin
               // Requests are ignored while a read is in flight.
               if (rsp_i.done) begin
                  req_q      <= 1'b0;
                  rd_ptr_q   <= rd_ptr_q + 1'b1;
                  rd_valid_o <= 1'b1;
                  state_q    <= AQ_IDLE;
               end
            end

            AQ_IDLE: begin
               if (reads_done) begin
                  finished_o <= 1'b1;
                  state_q    <= AQ_FINISHED;
               end else if (issue_rd) begin
                  req_q   <= 1'b1;
                  write_q <= 1'b0;
                  state_q <= AQ_READBACK;
               end
            end

            AQ_FINISHED: begin
               state_q <= AQ_FINISHED;   // Only reset leaves.
            end

            default: begin
               state_q <= AQ_WAITING;
            end
         endcase
      end
   end

   // Done only answers a raised request.
   a_done_with_req : assert property (@(posedge clock_i) disable iff (reset_i)
      rsp_i.done |-> req_q)
      else $error("acq_control: done without a pending request");

endmodule

/* source/sample_buffer.sv */
`timescale 1ns/10ps

module sample_buffer (
   input  logic             clock_i,
   input  logic             reset_i,
   input  logic             enable_i,
   input  logic             strobe_i,
   input  acq_pkg::sample_t sample_i,
   input  logic             pop_i,
   output logic             empty_n_o,
   output acq_pkg::sample_t head_o,
   output logic             overflow_o
);
   import acq_pkg::*;

   sample_t  mem [BUF_DEPTH];   // Block buffer storage.
   buf_ptr_t wr_ptr_q;
   buf_ptr_t rd_ptr_q;
   logic     full;
   logic     push;

   // --------------------
   // Status.
   // --------------------
   // Full when wrap bits differ but the addresses match.
   assign full = (wr_ptr_q[BUF_AW] != rd_ptr_q[BUF_AW]) &&
                 (wr_ptr_q[BUF_AW-1:0] == rd_ptr_q[BUF_AW-1:0]);
   assign push      = enable_i && strobe_i && !full;   // Drop when full.
   assign empty_n_o = (wr_ptr_q != rd_ptr_q);
   assign head_o    = mem[rd_ptr_q[BUF_AW-1:0]];        // Combinational head.

   // --------------------
   // Storage and pointers.
   // --------------------
   always_ff @(posedge clock_i) begin
      if (push) begin
         mem[wr_ptr_q[BUF_AW-1:0]] <= sample_i;
      end
   end

   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push)  wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // Sticky overflow, cleared while disabled.
   always_ff @(posedge clock_i) begin
      if (reset_i || !enable_i) begin
         overflow_o <= 1'b0;
      end else if (strobe_i && full) begin
         overflow_o <= 1'b1;   // Sample lost.
      end
   end

   // Controller pops only after forwarding a buffered word.
   a_no_pop_empty : assert property (@(posedge clock_i) disable iff (reset_i)
      pop_i |-> empty_n_o)
      else $error("sample_buffer: pop while empty");

endmodule

/* source/acq_pkg.sv */
package acq_pkg;

   // --------------------
   // Widths and depths.
   // --------------------
   localparam int SAMPLE_W    = 24;              // One raw sample.
   localparam int BUF_AW      = 4;               // Block buffer address bits.
   localparam int BUF_DEPTH   = 1 << BUF_AW;     // 16 entries.
   localparam int STORE_AW    = 6;               // Sample store address bits.
   localparam int STORE_DEPTH = 1 << STORE_AW;   // 64 words.
   localparam int BUS_DW      = 32;              // Wishbone data width.

   // --------------------
   // Vector types.
   // --------------------
   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [BUF_AW:0]     buf_ptr_t;       // MSB is the wrap bit.
   typedef logic [STORE_AW-1:0] store_adr_t;
   typedef logic [STORE_AW:0]   store_ptr_t;     // MSB marks a full pass.
   typedef logic [BUS_DW-1:0]   bus_data_t;

   // Acquisition and read-back states.
   typedef enum logic [2:0] {
      AQ_WAITING,
      AQ_BUFFERING,
      AQ_READBACK,
      AQ_IDLE,
      AQ_FINISHED
   } aq_state_t;

   // --------------------
   // Command port.
   // --------------------
   typedef struct packed {
      logic       request;    // Held until done.
      logic       write;
      store_adr_t address;
      sample_t    data;       // Write data only.
   } mem_cmd_t;

   typedef struct packed {
      logic    done;          // One-cycle pulse.
      sample_t data;          // Read data, valid with done.
   } mem_rsp_t;

   // --------------------
   // Wishbone classic.
   // --------------------
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      store_adr_t adr;
      bus_data_t  dat;
   } wb_m2s_t;

   typedef struct packed {
      logic      ack;
      bus_data_t dat;
   } wb_s2m_t;

endpackage
